/* Bender.yml */
package:
  name: rvseed

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rvseed_pkg.sv
      - verilog/pc_gen.sv
      - verilog/mem_arbiter.sv
      - axi/axi_master.sv
      - axi/axi_mem_slave.sv
      - fetch_ctrl/fetch_ctrl.sv
      - verilog/if_stage.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_if_stage.sv

/* axi/axi_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_settings.svh"

module axi_master (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rvseed_pkg::mem_req_t  req_i,
  output rvseed_pkg::mem_rsp_t  rsp_o,
  output logic                  done_o,
  // read address / data
  output logic                  axi_ar_valid_o,
  input  logic                  axi_ar_ready_i,
  output logic [`XLEN-1:0]      axi_ar_addr_o,
  input  logic                  axi_r_valid_i,
  output logic                  axi_r_ready_o,
  input  logic [`XLEN-1:0]      axi_r_data_i,
  input  rvseed_pkg::axi_resp_e axi_r_resp_i,
  // write address / data / response
  output logic                  axi_aw_valid_o,
  input  logic                  axi_aw_ready_i,
  output logic [`XLEN-1:0]      axi_aw_addr_o,
  output logic                  axi_w_valid_o,
  input  logic                  axi_w_ready_i,
  output logic [`XLEN-1:0]      axi_w_data_o,
  output logic [`XLEN/8-1:0]    axi_w_strb_o,
  input  logic                  axi_b_valid_i,
  output logic                  axi_b_ready_o,
  input  rvseed_pkg::axi_resp_e axi_b_resp_i
);
  import rvseed_pkg::*;

  axi_state_e state_q, state_d;
  mem_req_t   req_q;
  mem_rsp_t   rsp_q;
  logic       done_q;
  logic       accept, r_hs, b_hs;

  // done_q blocks the stale request still on the port for one cycle
  assign accept = (state_q == AX_IDLE) && req_i.valid && !done_q;
  assign r_hs   = (state_q == AX_R) && axi_r_valid_i && axi_r_ready_o;
  assign b_hs   = (state_q == AX_B) && axi_b_valid_i && axi_b_ready_o;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      AX_IDLE: if (accept)
        state_d = req_i.write ? AX_AW_W : AX_AR;
      AX_AR: if (axi_ar_ready_i)
        state_d = AX_R;
      AX_R: if (r_hs)
        state_d = AX_IDLE;
      // slave takes aw and w together
      AX_AW_W: if (axi_aw_ready_i && axi_w_ready_i)
        state_d = AX_B;
      AX_B: if (b_hs)
        state_d = AX_IDLE;
      default: state_d = AX_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= AX_IDLE;
      done_q  <= 1'b0;
      rsp_q   <= '0;
    end else begin
      state_q     <= state_d;
      done_q      <= r_hs || b_hs;
      rsp_q.valid <= r_hs;
      if (r_hs) begin
        rsp_q.err   <= (axi_r_resp_i == RESP_SLVERR);
        rsp_q.rdata <= axi_r_data_i;
      end else if (b_hs) begin
        // write status only, no read data
        rsp_q.err <= (axi_b_resp_i == RESP_SLVERR);
      end
    end
  end

  // request payload, held for the whole transaction
  always_ff @(posedge clk) begin
    if (accept)
      req_q <= req_i;
  end

  assign axi_ar_valid_o = (state_q == AX_AR);
  assign axi_ar_addr_o  = req_q.addr;
  // fixed read latency, never stall R
  assign axi_r_ready_o  = 1'b1;
  assign axi_aw_valid_o = (state_q == AX_AW_W);
  assign axi_aw_addr_o  = req_q.addr;
  assign axi_w_valid_o  = (state_q == AX_AW_W);
  assign axi_w_data_o   = req_q.wdata;
  assign axi_w_strb_o   = req_q.strb;
  assign axi_b_ready_o  = (state_q == AX_B);

  assign rsp_o  = rsp_q;
  assign done_o = done_q;

  // AR held with a stable address until the slave takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    (axi_ar_valid_o && !axi_ar_ready_i) |=> (axi_ar_valid_o && $stable(axi_ar_addr_o)));

endmodule

`default_nettype wire

/* axi/axi_mem_slave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_settings.svh"

module axi_mem_slave (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  axi_ar_valid_i,
  output logic                  axi_ar_ready_o,
  input  logic [`XLEN-1:0]      axi_ar_addr_i,
  output logic                  axi_r_valid_o,
  input  logic                  axi_r_ready_i,
  output logic [`XLEN-1:0]      axi_r_data_o,
  output rvseed_pkg::axi_resp_e axi_r_resp_o,
  input  logic                  axi_aw_valid_i,
  output logic                  axi_aw_ready_o,
  input  logic [`XLEN-1:0]      axi_aw_addr_i,
  input  logic                  axi_w_valid_i,
  output logic                  axi_w_ready_o,
  input  logic [`XLEN-1:0]      axi_w_data_i,
  input  logic [`XLEN/8-1:0]    axi_w_strb_i,
  output logic                  axi_b_valid_o,
  input  logic                  axi_b_ready_i,
  output rvseed_pkg::axi_resp_e axi_b_resp_o
);
  import rvseed_pkg::*;

  localparam int LAT   = `MEM_LAT;
  localparam int CNT_W = $clog2(LAT + 1);
  localparam int IDX_W = $clog2(`MEM_WORDS);

  logic [`XLEN-1:0] mem_q [`MEM_WORDS];
  logic             ar_ready_q, rd_busy_q, rd_err_q, ar_hs;
  logic [CNT_W-1:0] lat_cnt_q;
  logic [`XLEN-1:0] rd_addr_q;
  logic             wr_go, b_valid_q;
  axi_resp_e        b_resp_q;

  function automatic logic in_range(input logic [`XLEN-1:0] addr);
    return (addr >= `MEM_BASE) && (addr < `MEM_BASE + 8 * `MEM_WORDS);
  endfunction

  // ar ready one cycle after ar valid, one read at a time
  assign axi_ar_ready_o = ar_ready_q;
  assign ar_hs          = axi_ar_valid_i && ar_ready_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_ready_q <= 1'b0;
      rd_busy_q  <= 1'b0;
      rd_err_q   <= 1'b0;
      lat_cnt_q  <= '0;
    end else begin
      ar_ready_q <= axi_ar_valid_i && !ar_ready_q && !rd_busy_q;
      if (ar_hs) begin
        rd_busy_q <= 1'b1;
        rd_err_q  <= !in_range(axi_ar_addr_i);
        lat_cnt_q <= CNT_W'(LAT - 1);
      end else if (axi_r_valid_o && axi_r_ready_i) begin
        rd_busy_q <= 1'b0;
      end else if (rd_busy_q && lat_cnt_q != '0) begin
        lat_cnt_q <= lat_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs)
      rd_addr_q <= axi_ar_addr_i;
  end

  // out of range reads give zero data
  assign axi_r_valid_o = rd_busy_q && (lat_cnt_q == '0);
  assign axi_r_data_o  = rd_err_q ? '0 : mem_q[rd_addr_q[IDX_W+2:3]];
  assign axi_r_resp_o  = rd_err_q ? RESP_SLVERR : RESP_OKAY;

  // aw and w taken only as a pair, B a cycle later
  assign wr_go          = axi_aw_valid_i && axi_w_valid_i && !b_valid_q;
  assign axi_aw_ready_o = wr_go;
  assign axi_w_ready_o  = wr_go;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      b_valid_q <= 1'b0;
      b_resp_q  <= RESP_OKAY;
    end else if (wr_go) begin
      b_valid_q <= 1'b1;
      b_resp_q  <= in_range(axi_aw_addr_i) ? RESP_OKAY : RESP_SLVERR;
    end else if (b_valid_q && axi_b_ready_i) begin
      b_valid_q <= 1'b0;
    end
  end

  // per-byte strobe, memory untouched outside the window
  always_ff @(posedge clk) begin
    if (wr_go && in_range(axi_aw_addr_i)) begin
      for (int b = 0; b < `XLEN / 8; b++) begin
        if (axi_w_strb_i[b])
          mem_q[axi_aw_addr_i[IDX_W+2:3]][8*b +: 8] <= axi_w_data_i[8*b +: 8];
      end
    end
  end

  assign axi_b_valid_o = b_valid_q;
  assign axi_b_resp_o  = b_resp_q;

  // R beat exactly MEM_LAT cycles after the AR handshake
  assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs |-> ##LAT axi_r_valid_o);

endmodule

`default_nettype wire

/* common/rvseed_pkg.sv */
`default_nettype none

`include "rvseed_settings.svh"

package rvseed_pkg;

  // one request on the shared memory port
  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [`XLEN-1:0]     addr;
    logic [`XLEN-1:0]     wdata;
    logic [`XLEN/8-1:0]   strb;
  } mem_req_t;

  // one result back from the port
  typedef struct packed {
    logic                 valid;
    logic                 err;
    logic [`XLEN-1:0]     rdata;
  } mem_rsp_t;

  // fetched instruction with its own pc
  typedef struct packed {
    logic                 valid;
    logic [`XLEN-1:0]     pc;
    logic [`INST_W-1:0]   inst;
  } inst_t;

  // new pc from the back end
  typedef struct packed {
    logic                 valid;
    logic [`XLEN-1:0]     target;
  } redirect_t;

  // who currently owns the memory port
  typedef enum logic [1:0] {ID_NONE, ID_FETCH, ID_DATA} req_id_e;

  typedef enum logic [1:0] {FS_IDLE, FS_ISSUE, FS_WAIT, FS_DROP} fetch_state_e;

  typedef enum logic [2:0] {AX_IDLE, AX_AR, AX_R, AX_AW_W, AX_B} axi_state_e;

  // only the two codes this slave ever returns
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire

/* common/rvseed_settings.svh */
`ifndef RVSEED_SETTINGS_SVH
`define RVSEED_SETTINGS_SVH

// address and data width
`define XLEN 64
// instruction word width
`define INST_W 32

// first fetch address out of reset
`define RESET_PC 64'h0000_0000_8000_0000

// base of the memory slave window
`define MEM_BASE 64'h0000_0000_8000_0000
// 64-bit words in the slave
`define MEM_WORDS 256
// cycles from AR handshake to R valid
`define MEM_LAT 3

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

/* fetch_ctrl/fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_settings.svh"

module fetch_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rvseed_pkg::redirect_t redirect_i,
  input  logic                  stall_i,
  input  logic [`XLEN-1:0]      pc_i,
  input  rvseed_pkg::mem_rsp_t  fetch_rsp_i,
  output rvseed_pkg::mem_req_t  fetch_req_o,
  output logic                  pc_adv_o,
  output logic                  pc_load_o,
  output rvseed_pkg::inst_t     inst_o
);
  import rvseed_pkg::*;

  fetch_state_e state_q, state_d;
  logic         hit;

  // live result of a fetch nobody redirected away from
  assign hit = (state_q == FS_ISSUE || state_q == FS_WAIT) &&
               fetch_rsp_i.valid && !redirect_i.valid;

  assign pc_load_o = redirect_i.valid;
  assign pc_adv_o  = hit;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // stay idle on redirect so the flight pc picks up the target
      FS_IDLE: if (!redirect_i.valid && !stall_i)
        state_d = FS_ISSUE;
      FS_ISSUE, FS_WAIT: begin
        if (fetch_rsp_i.valid)
          state_d = FS_IDLE;
        else if (redirect_i.valid)
          state_d = FS_DROP;
        else
          state_d = FS_WAIT;
      end
      // stale fetch still owns the port, wait it out
      FS_DROP: if (fetch_rsp_i.valid)
        state_d = FS_IDLE;
      default: state_d = FS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state_q <= FS_IDLE;
    else
      state_q <= state_d;
  end

  // request held as a level until its result is back
  always_comb begin
    fetch_req_o       = '0;
    fetch_req_o.valid = (state_q != FS_IDLE);
    fetch_req_o.addr  = pc_i;
  end

  // pick the 32-bit half by pc bit 2, bus error shows as nop
  always_comb begin
    inst_o.valid = hit;
    inst_o.pc    = pc_i;
    inst_o.inst  = `NOP_INST;
    if (hit && !fetch_rsp_i.err)
      inst_o.inst = pc_i[2] ? fetch_rsp_i.rdata[2*`INST_W-1:`INST_W]
                            : fetch_rsp_i.rdata[`INST_W-1:0];
  end

  // a stalled idle cycle never launches a request
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == FS_IDLE && stall_i) |=> !fetch_req_o.valid);

endmodule

`default_nettype wire

/* tests/tb_if_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_settings.svh"

module tb_if_stage;
  import rvseed_pkg::*;

  // preloaded words hold 64 instructions
  localparam int NW       = 32;
  localparam int WAIT_MAX = 200;

  logic      clk;
  logic      rst_n;
  redirect_t redirect_i;
  logic      stall_i;
  mem_req_t  data_req_i;
  inst_t     inst_o;
  mem_rsp_t  data_rsp_o;
  logic      wr_done_o;

  // mirror of every store into the low words
  logic [`XLEN-1:0] sb_mem [NW];
  logic [15:0]      lfsr_q = 16'd87;
  logic [`XLEN-1:0] exp_pc;
  int               inst_cnt;
  int               stall_valids;
  int               value_errs = 0;
  int               timeout_errs = 0;

  if_stage u_if_stage (
    .clk(clk), .rst_n(rst_n), .redirect_i(redirect_i), .stall_i(stall_i),
    .data_req_i(data_req_i), .inst_o(inst_o), .data_rsp_o(data_rsp_o), .wr_done_o(wr_done_o)
  );

  always #2 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [`XLEN-1:0] rand_bits(input int n);
    logic [`XLEN-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[`XLEN-2:0], lfsr_bit()};
    return v;
  endfunction

  function automatic logic in_slave(input logic [`XLEN-1:0] a);
    return (a >= `MEM_BASE) && (a < `MEM_BASE + 8 * `MEM_WORDS);
  endfunction

  function automatic int word_idx(input logic [`XLEN-1:0] a);
    return int'((a - `MEM_BASE) >> 3);
  endfunction

  // outside the slave a fetch shows nop
  // inside only mirrored words are known
  function automatic logic inst_known(input logic [`XLEN-1:0] pc);
    return !in_slave(pc) || (word_idx(pc) < NW);
  endfunction

  function automatic logic [`INST_W-1:0] expected_inst(input logic [`XLEN-1:0] pc);
    if (!in_slave(pc))
      return `NOP_INST;
    return pc[2] ? sb_mem[word_idx(pc)][63:32] : sb_mem[word_idx(pc)][31:0];
  endfunction

  task automatic report_value(input string msg);
    value_errs++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    timeout_errs++;
    $display("timeout at %0t ns: no %s arrived in time", $time, what);
  endtask

  task automatic store_word(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data,
                            input logic [7:0] strb);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    @(negedge clk);
    data_req_i.valid = 1'b1;
    data_req_i.write = 1'b1;
    data_req_i.addr  = addr;
    data_req_i.wdata = data;
    data_req_i.strb  = strb;
    while (!done && n < WAIT_MAX) begin
      @(negedge clk);
      done = wr_done_o;
      n++;
    end
    data_req_i = '0;
    if (!done)
      report_timeout("store completion");
    else if (in_slave(addr) && word_idx(addr) < NW)
      for (int b = 0; b < 8; b++)
        if (strb[b])
          sb_mem[word_idx(addr)][8*b +: 8] = data[8*b +: 8];
  endtask

  task automatic check_load(input logic [`XLEN-1:0] addr);
    int       n;
    logic     got;
    mem_rsp_t rsp;
    n   = 0;
    got = 1'b0;
    @(negedge clk);
    data_req_i.valid = 1'b1;
    data_req_i.write = 1'b0;
    data_req_i.addr  = addr;
    while (!got && n < WAIT_MAX) begin
      @(negedge clk);
      got = data_rsp_o.valid;
      rsp = data_rsp_o;
      n++;
    end
    data_req_i = '0;
    if (!got) begin
      report_timeout("load data");
    end else if (!in_slave(addr)) begin
      assert (rsp.err && rsp.rdata === '0)
        else report_value($sformatf("load %h outside memory: err %b data %h",
                                    addr, rsp.err, rsp.rdata));
    end else begin
      assert (!rsp.err && rsp.rdata === sb_mem[word_idx(addr)])
        else report_value($sformatf("load %h: got %h err %b, expected %h",
                                    addr, rsp.rdata, rsp.err, sb_mem[word_idx(addr)]));
    end
  endtask

  task automatic wait_insts(input int n);
    int goal;
    int t;
    goal = inst_cnt + n;
    t    = 0;
    while (inst_cnt < goal && t < WAIT_MAX * n) begin
      @(negedge clk);
      t++;
    end
    if (inst_cnt < goal)
      report_timeout("fetched instruction");
  endtask

  task automatic pulse_redirect(input logic [`XLEN-1:0] target);
    @(negedge clk);
    redirect_i.valid  = 1'b1;
    redirect_i.target = target;
    @(negedge clk);
    redirect_i = '0;
  endtask

  // expected pc and stall bookkeeping
  // content check per strobe
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc       <= `RESET_PC;
      inst_cnt     <= 0;
      stall_valids <= 0;
    end else begin
      if (redirect_i.valid)
        exp_pc <= redirect_i.target;
      else if (inst_o.valid)
        exp_pc <= exp_pc + `XLEN'd4;
      if (inst_o.valid)
        inst_cnt <= inst_cnt + 1;
      if (!stall_i)
        stall_valids <= 0;
      else if (inst_o.valid)
        stall_valids <= stall_valids + 1;
      if (inst_o.valid && inst_known(inst_o.pc)) begin
        assert (inst_o.inst === expected_inst(inst_o.pc))
          else report_value($sformatf("inst at pc %h is %h, expected %h",
                                      inst_o.pc, inst_o.inst, expected_inst(inst_o.pc)));
      end
    end
  end

  // nop on the instruction word without a strobe
  assert property (@(posedge clk) disable iff (!rst_n)
    !inst_o.valid |-> inst_o.inst == `NOP_INST)
    else report_value("instruction word not nop while idle");

  // sequential pc or the redirect target
  assert property (@(posedge clk) disable iff (!rst_n) inst_o.valid |-> inst_o.pc == exp_pc)
    else report_value($sformatf("inst pc %h, expected %h", inst_o.pc, exp_pc));

  // only the fetch already out may finish under stall
  assert property (@(posedge clk) disable iff (!rst_n) stall_valids <= 1)
    else report_value("instruction fetched while stalled");

  // one owner means one result per cycle
  assert property (@(posedge clk) disable iff (!rst_n) inst_o.valid |-> !data_rsp_o.valid)
    else report_value("fetch and load result in the same cycle");

  assert property (@(posedge clk)
    $rose(rst_n) |-> !inst_o.valid && !data_rsp_o.valid && !wr_done_o)
    else report_value("output strobe high right after reset");

  initial begin
    logic [7:0] strb;
    clk        = 1'b0;
    rst_n      = 1'b0;
    redirect_i = '0;
    stall_i    = 1'b1;
    data_req_i = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (!inst_o.valid && !data_rsp_o.valid && inst_o.inst == `NOP_INST)
      else report_value("outputs not idle after reset");
    // program preload with full words then partial strobes
    for (int i = 0; i < NW; i++)
      store_word(`MEM_BASE + 8 * i, rand_bits(64), 8'hff);
    for (int i = 0; i < 8; i++) begin
      strb = {1'b0, rand_bits(7)} | 8'h01;
      store_word(`MEM_BASE + 8 * rand_bits(5), rand_bits(64), strb);
    end
    store_word(`MEM_BASE + 8 * `MEM_WORDS, rand_bits(64), 8'hff);
    for (int i = 0; i < NW; i++)
      check_load(`MEM_BASE + 8 * i);
    check_load(`MEM_BASE + 8 * `MEM_WORDS);
    // sequential fetch from reset pc
    stall_i = 1'b0;
    wait_insts(6);
    // redirect lands on a fetch in flight
    pulse_redirect(`RESET_PC + 4 * rand_bits(5));
    wait_insts(4);
    // load racing the next fetch
    check_load(`MEM_BASE + 8 * rand_bits(5));
    wait_insts(2);
    // stall with a fetch out
    @(negedge clk);
    stall_i = 1'b1;
    repeat (40) @(negedge clk);
    stall_i = 1'b0;
    wait_insts(2);
    // fetch below the memory window
    @(negedge clk);
    stall_i = 1'b1;
    repeat (30) @(negedge clk);
    pulse_redirect(64'h0000_0000_4000_0000);
    stall_i = 1'b0;
    wait_insts(3);
    stall_i = 1'b1;
    repeat (20) @(negedge clk);
    $display("errors: value %0d, timeout %0d", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/rvseed_pkg.sv
verilog/pc_gen.sv
verilog/mem_arbiter.sv
axi/axi_master.sv
axi/axi_mem_slave.sv
fetch_ctrl/fetch_ctrl.sv
verilog/if_stage.sv
tests/tb_if_stage.sv

/* verilog/if_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_settings.svh"

module if_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rvseed_pkg::redirect_t redirect_i,
  input  logic                  stall_i,
  input  rvseed_pkg::mem_req_t  data_req_i,
  output rvseed_pkg::inst_t     inst_o,
  output rvseed_pkg::mem_rsp_t  data_rsp_o,
  output logic                  wr_done_o
);
  import rvseed_pkg::*;

  // fetch side
  mem_req_t         fetch_req;
  mem_rsp_t         fetch_rsp;
  logic             pc_adv;
  logic             pc_load;
  logic [`XLEN-1:0] flight_pc;
  // shared port between arbiter and master
  mem_req_t         port_req;
  mem_rsp_t         port_rsp;
  logic             port_done;
  // axi channels
  logic             ar_valid, ar_ready, r_valid, r_ready;
  logic [`XLEN-1:0] ar_addr, r_data;
  axi_resp_e        r_resp, b_resp;
  logic             aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic [`XLEN-1:0] aw_addr, w_data;
  logic [`XLEN/8-1:0] w_strb;

  fetch_ctrl u_fetch_ctrl (
    .clk(clk), .rst_n(rst_n), .redirect_i(redirect_i), .stall_i(stall_i),
    .pc_i(flight_pc), .fetch_rsp_i(fetch_rsp), .fetch_req_o(fetch_req),
    .pc_adv_o(pc_adv), .pc_load_o(pc_load), .inst_o(inst_o)
  );

  // flight pc freezes while the fetch request is up
  pc_gen u_pc_gen (
    .clk(clk), .rst_n(rst_n), .pc_adv_i(pc_adv), .pc_load_i(pc_load),
    .target_i(redirect_i.target), .issue_i(fetch_req.valid),
    .pc_o(), .flight_pc_o(flight_pc)
  );

  mem_arbiter u_mem_arbiter (
    .clk(clk), .rst_n(rst_n), .fetch_req_i(fetch_req), .data_req_i(data_req_i),
    .port_rsp_i(port_rsp), .port_done_i(port_done), .port_req_o(port_req),
    .fetch_rsp_o(fetch_rsp), .data_rsp_o(data_rsp_o), .wr_done_o(wr_done_o)
  );

  axi_master u_axi_master (
    .clk(clk), .rst_n(rst_n), .req_i(port_req), .rsp_o(port_rsp), .done_o(port_done),
    .axi_ar_valid_o(ar_valid), .axi_ar_ready_i(ar_ready), .axi_ar_addr_o(ar_addr),
    .axi_r_valid_i(r_valid), .axi_r_ready_o(r_ready), .axi_r_data_i(r_data),
    .axi_r_resp_i(r_resp), .axi_aw_valid_o(aw_valid), .axi_aw_ready_i(aw_ready),
    .axi_aw_addr_o(aw_addr), .axi_w_valid_o(w_valid), .axi_w_ready_i(w_ready),
    .axi_w_data_o(w_data), .axi_w_strb_o(w_strb), .axi_b_valid_i(b_valid),
    .axi_b_ready_o(b_ready), .axi_b_resp_i(b_resp)
  );

  axi_mem_slave u_axi_mem_slave (
    .clk(clk), .rst_n(rst_n),
    .axi_ar_valid_i(ar_valid), .axi_ar_ready_o(ar_ready), .axi_ar_addr_i(ar_addr),
    .axi_r_valid_o(r_valid), .axi_r_ready_i(r_ready), .axi_r_data_o(r_data),
    .axi_r_resp_o(r_resp), .axi_aw_valid_i(aw_valid), .axi_aw_ready_o(aw_ready),
    .axi_aw_addr_i(aw_addr), .axi_w_valid_i(w_valid), .axi_w_ready_o(w_ready),
    .axi_w_data_i(w_data), .axi_w_strb_i(w_strb), .axi_b_valid_o(b_valid),
    .axi_b_ready_i(b_ready), .axi_b_resp_o(b_resp)
  );

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rvseed_pkg::mem_req_t fetch_req_i,
  input  rvseed_pkg::mem_req_t data_req_i,
  input  rvseed_pkg::mem_rsp_t port_rsp_i,
  input  logic                 port_done_i,
  output rvseed_pkg::mem_req_t port_req_o,
  output rvseed_pkg::mem_rsp_t fetch_rsp_o,
  output rvseed_pkg::mem_rsp_t data_rsp_o,
  output logic                 wr_done_o
);
  import rvseed_pkg::*;

  req_id_e owner_q;

  // grant only from idle, data side first
  // owner held until the master reports done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q <= ID_NONE;
    end else if (owner_q == ID_NONE) begin
      if (data_req_i.valid)
        owner_q <= ID_DATA;
      else if (fetch_req_i.valid)
        owner_q <= ID_FETCH;
    end else if (port_done_i) begin
      owner_q <= ID_NONE;
    end
  end

  // requesters hold their payload, so a plain mux is enough
  always_comb begin
    unique case (owner_q)
      ID_DATA:  port_req_o = data_req_i;
      ID_FETCH: port_req_o = fetch_req_i;
      default:  port_req_o = '0;
    endcase
  end

  // steer the result back by owner
  always_comb begin
    fetch_rsp_o       = port_rsp_i;
    fetch_rsp_o.valid = port_rsp_i.valid && (owner_q == ID_FETCH);
    data_rsp_o        = port_rsp_i;
    data_rsp_o.valid  = port_rsp_i.valid && (owner_q == ID_DATA);
  end

  // stores have no read data, only the B completion
  assign wr_done_o = port_done_i && (owner_q == ID_DATA) && data_req_i.write;

  // owner is stable for the whole transaction
  assert property (@(posedge clk) disable iff (!rst_n)
    (owner_q != ID_NONE && !port_done_i) |=> $stable(owner_q));

  // master never finishes something that was not granted
  assert property (@(posedge clk) disable iff (!rst_n)
    port_done_i |-> (owner_q != ID_NONE));

endmodule

`default_nettype wire

/* verilog/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_settings.svh"

module pc_gen (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pc_adv_i,
  input  logic             pc_load_i,
  input  logic [`XLEN-1:0] target_i,
  input  logic             issue_i,
  output logic [`XLEN-1:0] pc_o,
  output logic [`XLEN-1:0] flight_pc_o
);

  // next pc to fetch
  logic [`XLEN-1:0] pc_q;
  // pc of the fetch currently out
  logic [`XLEN-1:0] flight_q;

  // redirect beats sequential advance
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      pc_q <= `RESET_PC;
    else if (pc_load_i)
      pc_q <= target_i;
    else if (pc_adv_i)
      pc_q <= pc_q + `XLEN'd4;
  end

  // follows pc while nothing is issued
  // frozen for the whole fetch so a redirect cannot relabel it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      flight_q <= `RESET_PC;
    else if (!issue_i)
      flight_q <= pc_q;
  end

  assign pc_o        = pc_q;
  assign flight_pc_o = flight_q;

endmodule

`default_nettype wire
